// ==== pit8253.f ====
+incdir+hdl
hdl/pit_reg_pkg.sv
hdl/pit_count_pkg.sv
hdl/pit_axil_regs.sv
hdl/pit_counter.sv
hdl/pit_top.sv
sim/pit_chk.sv
sim/pit_tb.sv

// ==== Bender.yml ====
package:
  name: pit8253

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pit_reg_pkg.sv
      - hdl/pit_count_pkg.sv
      - hdl/pit_axil_regs.sv
      - hdl/pit_counter.sv
      - hdl/pit_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - sim/pit_chk.sv
      - sim/pit_tb.sv

// ==== sim/pit_golden.txt ====
# Columns: W offset data | R offset byte hold | T counter ticks | G gate | E out
# offset, data, byte in hex; counter, ticks, hold in decimal; gate and out binary [2:0]
E 111
W C 30
W 0 05
W 0 00
T 0 5
E 110
T 0 1
E 111
T 0 3
E 111
W C 74
W 4 04
W 4 00
T 1 3
E 111
T 1 1
E 101
T 1 1
E 111
T 1 3
E 101
T 1 4
E 101
W C B6
W 8 06
W 8 00
T 2 3
E 101
T 2 2
E 001
G 011
T 2 4
E 001
R 8 04 0
G 111
T 2 2
E 101
W C 58
W 4 03
T 1 3
E 111
T 1 1
E 101
T 1 4
E 111
W C 30
W 0 34
W 0 12
T 0 5
W C 00
T 0 2
R 0 30 0
T 0 3
R 0 12 0
R 0 2B 6
R 0 12 0
R C 00 4
E 110

// ==== sim/pit_tb.sv ====
// Timer testbench: clock and reset, AXI4-Lite tasks, golden-file interpreter, checks, verdict
`timescale 1ns/1ps
`include "pit_consts.svh"

module pit_tb;

  localparam int DRV_DLY = 10;
  localparam int TMO     = 40;

  logic                    WR_;
  logic                    LOAD;
  pit_reg_pkg::axil_req_t  axil_req;
  pit_reg_pkg::axil_rsp_t  axil_rsp;
  logic [`PIT_NUM_CNT-1:0] cnt_clk;
  logic [`PIT_NUM_CNT-1:0] gate;
  logic [`PIT_NUM_CNT-1:0] out;
  int                      n_checks;

  pit_top DUT (
    .WR_      (WR_),
    .LOAD     (LOAD),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .cnt_clk  (cnt_clk),
    .gate     (gate),
    .out      (out)
  );

  initial begin
    WR_ = 1'b0;
    forever #50 WR_ = ~WR_;
  end

  task automatic fail_now();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic timed_out(input string chan);
    $display("Timed out after %0d cycles waiting on the %s channel", TMO, chan);
    fail_now();
  endtask

  task automatic check_rdata(input pit_reg_pkg::axil_rsp_t rsp, input logic [7:0] exp_byte);
    logic [`PIT_DATA_W-1:0] exp_data;
    exp_data = {{(`PIT_DATA_W-8){1'b0}}, exp_byte};
    n_checks++;
    if (rsp.rdata !== exp_data) begin
      $display("[ERROR] rdata expected 0x%h actual 0x%h", exp_data, rsp.rdata);
      fail_now();
    end
    // OKAY is the only response
    if (rsp.rresp !== 2'b00) begin
      $display("[ERROR] rresp expected 0x0 actual 0x%h", rsp.rresp);
      fail_now();
    end
  endtask

  task automatic check_bresp(input pit_reg_pkg::axil_rsp_t rsp);
    n_checks++;
    if (rsp.bresp !== 2'b00) begin
      $display("[ERROR] bresp expected 0x0 actual 0x%h", rsp.bresp);
      fail_now();
    end
  endtask

  task automatic check_out(input logic [2:0] exp_out, input logic [2:0] act_out);
    n_checks++;
    if (act_out !== exp_out) begin
      $display("[ERROR] out expected 0x%h actual 0x%h", exp_out, act_out);
      fail_now();
    end
  endtask

  task automatic axil_write(input logic [3:0] addr, input logic [7:0] data);
    int n;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wdata   = {{(`PIT_DATA_W-8){1'b0}}, data};
    n = 0;
    @(negedge WR_);
    while (!(axil_rsp.awready && axil_rsp.wready)) begin
      n++;
      if (n > TMO) timed_out("write address and data");
      @(negedge WR_);
    end
    @(posedge WR_);
    #DRV_DLY;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    n = 0;
    @(negedge WR_);
    while (!axil_rsp.bvalid) begin
      n++;
      if (n > TMO) timed_out("write response");
      @(negedge WR_);
    end
    check_bresp(axil_rsp);
    @(posedge WR_);
    #DRV_DLY;
  endtask

  // Read with rready held low for hold cycles once rvalid is up
  task automatic axil_read(input logic [3:0] addr, input logic [7:0] exp_byte, input int hold);
    int n;
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    n = 0;
    @(negedge WR_);
    while (!axil_rsp.arready) begin
      n++;
      if (n > TMO) timed_out("read address");
      @(negedge WR_);
    end
    @(posedge WR_);
    #DRV_DLY;
    axil_req.arvalid = 1'b0;
    n = 0;
    @(negedge WR_);
    while (!axil_rsp.rvalid) begin
      n++;
      if (n > TMO) timed_out("read data");
      @(negedge WR_);
    end
    for (int i = 0; i < hold; i++) begin
      check_rdata(axil_rsp, exp_byte);
      @(negedge WR_);
    end
    @(posedge WR_);
    #DRV_DLY;
    axil_req.rready = 1'b1;
    @(negedge WR_);
    if (!axil_rsp.rvalid) begin
      $display("Read response was withdrawn before rready");
      fail_now();
    end
    check_rdata(axil_rsp, exp_byte);
    @(posedge WR_);
    #DRV_DLY;
    axil_req.rready = 1'b0;
  endtask

  // Each tick holds the pin high for 5 cycles and low for 5 cycles
  // Both halves outlast the pin-to-out latency
  task automatic pulse_cnt_clk(input int idx, input int n);
    for (int k = 0; k < n; k++) begin
      cnt_clk[idx] = 1'b1;
      repeat (5) @(posedge WR_);
      #DRV_DLY;
      cnt_clk[idx] = 1'b0;
      repeat (5) @(posedge WR_);
      #DRV_DLY;
    end
  endtask

  always @(negedge WR_) begin
    if (DUT.u_regs.u_chk.fail_cnt != 0) begin
      $display("An AXI4-Lite protocol assertion fired");
      fail_now();
    end
  end

  initial begin
    int              fd;
    int              r;
    logic [63:0]     cmd;
    logic [8*128-1:0] rest;
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     c;
    n_checks        = 0;
    LOAD            = 1'b1;
    axil_req        = '0;
    axil_req.bready = 1'b1;
    cnt_clk         = '0;
    gate            = '1;
    repeat (4) @(posedge WR_);
    #DRV_DLY;
    LOAD = 1'b0;
    fd = $fopen("sim/pit_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open sim/pit_golden.txt");
      fail_now();
    end
    forever begin
      cmd = '0;
      if ($fscanf(fd, "%s", cmd) != 1) break;
      case (cmd)
        "#": r = $fgets(rest, fd);
        "W": begin
          r = $fscanf(fd, "%h %h", a, b);
          axil_write(a[3:0], b[7:0]);
        end
        "R": begin
          r = $fscanf(fd, "%h %h %d", a, b, c);
          axil_read(a[3:0], b[7:0], int'(c));
        end
        "T": begin
          r = $fscanf(fd, "%d %d", a, b);
          pulse_cnt_clk(int'(a), int'(b));
        end
        "G": begin
          r = $fscanf(fd, "%b", a);
          gate = a[2:0];
        end
        "E": begin
          r = $fscanf(fd, "%b", a);
          @(negedge WR_);
          check_out(a[2:0], out);
          @(posedge WR_);
          #DRV_DLY;
        end
        default: begin
          $display("Unknown command in the golden file");
          fail_now();
        end
      endcase
    end
    $fclose(fd);
    if (n_checks > 0) begin
      $display("test passed");
    end else begin
      $display("The golden file held no checks");
      fail_now();
    end
    $finish;
  end

endmodule

// ==== sim/pit_chk.sv ====
// AXI4-Lite handshake assertions for the register block and their bind
`timescale 1ns/1ps

module pit_chk (
  input logic                   WR_,
  input logic                   LOAD,
  input pit_reg_pkg::axil_req_t axil_req,
  input pit_reg_pkg::axil_rsp_t axil_rsp
);

  int   fail_cnt = 0;
  logic aw_wait;
  logic ar_wait;
  logic b_wait;
  logic r_wait;
  logic ar_acc;

  assign aw_wait = axil_req.awvalid & ~axil_rsp.awready;
  assign ar_wait = axil_req.arvalid & ~axil_rsp.arready;
  assign b_wait  = axil_rsp.bvalid & ~axil_req.bready;
  assign r_wait  = axil_rsp.rvalid & ~axil_req.rready;
  assign ar_acc  = axil_req.arvalid & axil_rsp.arready;

  // Master side requests held until accepted
  a_req_hold: assert property (@(posedge WR_) disable iff (LOAD)
    (!$past(aw_wait) || axil_req.awvalid) && (!$past(ar_wait) || axil_req.arvalid))
    else begin
      fail_cnt++;
      $error("awvalid or arvalid dropped before its ready");
    end

  // Responses held under back-pressure
  a_rsp_hold: assert property (@(posedge WR_) disable iff (LOAD)
    (!$past(b_wait) || axil_rsp.bvalid) && (!$past(r_wait) || axil_rsp.rvalid))
    else begin
      fail_cnt++;
      $error("bvalid or rvalid dropped before its ready");
    end

  a_rd_cause: assert property (@(posedge WR_) disable iff (LOAD)
    !$rose(axil_rsp.rvalid) || $past(ar_acc))
    else begin
      fail_cnt++;
      $error("rvalid rose without an accepted read address");
    end

endmodule

bind pit_axil_regs pit_chk u_chk (
  .WR_      (WR_),
  .LOAD     (LOAD),
  .axil_req (axil_req),
  .axil_rsp (axil_rsp)
);

// ==== hdl/pit_top.sv ====
// Timer top level: AXI4-Lite register block beside three counters
`timescale 1ns/1ps
`include "pit_consts.svh"

module pit_top (
  input  logic                    WR_,
  input  logic                    LOAD,
  input  pit_reg_pkg::axil_req_t  axil_req,
  output pit_reg_pkg::axil_rsp_t  axil_rsp,
  input  logic [`PIT_NUM_CNT-1:0] cnt_clk,
  input  logic [`PIT_NUM_CNT-1:0] gate,
  output logic [`PIT_NUM_CNT-1:0] out
);

  pit_count_pkg::cnt_cfg_t  cfg  [`PIT_NUM_CNT];
  pit_count_pkg::cnt_stat_t stat [`PIT_NUM_CNT];

  pit_axil_regs u_regs (
    .WR_      (WR_),
    .LOAD     (LOAD),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .cfg      (cfg),
    .stat     (stat)
  );

  for (genvar i = 0; i < `PIT_NUM_CNT; i++) begin : g_cnt
    pit_counter u_cnt (
      .WR_     (WR_),
      .LOAD    (LOAD),
      .cfg     (cfg[i]),
      .cnt_clk (cnt_clk[i]),
      .gate    (gate[i]),
      .stat    (stat[i]),
      .out     (out[i])
    );
  end

endmodule

// ==== hdl/pit_counter.sv ====
// One timer counter: pin synchronizers, tick detect, 16-bit down counter, mode output control
`timescale 1ns/1ps
`include "pit_consts.svh"

module pit_counter (
  input  logic                     WR_,
  input  logic                     LOAD,
  input  pit_count_pkg::cnt_cfg_t  cfg,
  input  logic                     cnt_clk,
  input  logic                     gate,
  output pit_count_pkg::cnt_stat_t stat,
  output logic                     out
);

  // Bit 1 is gate, bit 0 is the counter clock
  logic [1:0]  pin_sync [`PIT_SYNC_STAGES];
  logic        clk_s;
  logic        gate_s;
  logic        clk_d;
  logic        tick;

  logic        armed;
  logic        running;
  logic [15:0] count;

  // Square wave reload values, odd counts give the high half one extra tick
  logic [15:0] sq_even;
  logic [15:0] sq_hi;

  assign clk_s   = pin_sync[`PIT_SYNC_STAGES-1][0];
  assign gate_s  = pin_sync[`PIT_SYNC_STAGES-1][1];
  assign sq_even = {cfg.init[15:1], 1'b0};
  assign sq_hi   = sq_even + {14'd0, cfg.init[0], 1'b0};

  // Synchronizer chain and registered rising-edge detect
  always_ff @(posedge WR_ or posedge LOAD) begin
    if (LOAD) begin
      for (int i = 0; i < `PIT_SYNC_STAGES; i++) begin
        pin_sync[i] <= 2'b00;
      end
      clk_d <= 1'b0;
      tick  <= 1'b0;
    end else begin
      pin_sync[0] <= {gate, cnt_clk};
      for (int i = 1; i < `PIT_SYNC_STAGES; i++) begin
        pin_sync[i] <= pin_sync[i-1];
      end
      clk_d <= clk_s;
      tick  <= clk_s & ~clk_d;
    end
  end

  always_ff @(posedge WR_ or posedge LOAD) begin
    if (LOAD) begin
      armed   <= 1'b0;
      running <= 1'b0;
      count   <= 16'h0000;
      out     <= 1'b1;
    end else if (cfg.stop) begin
      // New control word halts until the next count arrives
      armed   <= 1'b0;
      running <= 1'b0;
      out     <= (cfg.mode != pit_count_pkg::MODE_TERMINAL);
    end else if (cfg.arm) begin
      armed <= 1'b1;
      if (cfg.mode == pit_count_pkg::MODE_TERMINAL) out <= 1'b0;
    end else if (tick) begin
      if (armed) begin
        // First tick after arm loads N, gate or not
        armed   <= 1'b0;
        running <= 1'b1;
        count   <= (cfg.mode == pit_count_pkg::MODE_SQUARE) ? sq_hi : cfg.init;
        if (cfg.mode != pit_count_pkg::MODE_TERMINAL) out <= 1'b1;
      end else if (running && gate_s) begin
        case (cfg.mode)
          pit_count_pkg::MODE_RATE: begin
            if (count == 16'd1) begin
              count <= cfg.init;
              out   <= 1'b1;
            end else begin
              count <= count - 16'd1;
              // Low for the tick spent at count 1
              out   <= (count != 16'd2);
            end
          end
          pit_count_pkg::MODE_SQUARE: begin
            if (count <= 16'd2) begin
              count <= out ? sq_even : sq_hi;
              out   <= ~out;
            end else begin
              count <= count - 16'd2;
            end
          end
          pit_count_pkg::MODE_STROBE: begin
            if (count == 16'd0) begin
              // Strobe done, no reload
              running <= 1'b0;
              out     <= 1'b1;
            end else begin
              count <= count - 16'd1;
              out   <= (count != 16'd1);
            end
          end
          default: begin
            // Terminal count, keeps wrapping with out held high
            count <= count - 16'd1;
            if (count == 16'd1) out <= 1'b1;
          end
        endcase
      end
    end
  end

  assign stat.count = count;

endmodule

// ==== hdl/pit_axil_regs.sv ====
// AXI4-Lite slave with control-word decode, count byte sequencing, read-back and latch
`timescale 1ns/1ps
`include "pit_consts.svh"

module pit_axil_regs (
  input  logic                     WR_,
  input  logic                     LOAD,
  input  pit_reg_pkg::axil_req_t   axil_req,
  output pit_reg_pkg::axil_rsp_t   axil_rsp,
  output pit_count_pkg::cnt_cfg_t  cfg  [`PIT_NUM_CNT],
  input  pit_count_pkg::cnt_stat_t stat [`PIT_NUM_CNT]
);

  // Word offset of the control register
  localparam logic [1:0] CTRL_IDX = 2'd3;

  typedef enum logic {
    CH_IDLE,
    CH_RESP
  } chan_e;

  chan_e                    wr_st;
  chan_e                    rd_st;
  logic                     wr_hs;
  logic                     rd_hs;
  logic [1:0]               wr_idx;
  logic [1:0]               rd_idx;
  logic [7:0]               wr_byte;
  pit_reg_pkg::access_e     wr_acc;

  pit_reg_pkg::access_e     acc       [`PIT_NUM_CNT];
  pit_count_pkg::cnt_mode_e mode      [`PIT_NUM_CNT];
  logic [15:0]              init      [`PIT_NUM_CNT];
  logic [15:0]              latch     [`PIT_NUM_CNT];
  logic [`PIT_NUM_CNT-1:0]  wr_msb;
  logic [`PIT_NUM_CNT-1:0]  rd_msb;
  logic [`PIT_NUM_CNT-1:0]  latch_vld;
  logic [`PIT_NUM_CNT-1:0]  arm_q;
  logic [`PIT_NUM_CNT-1:0]  stop_q;

  // Per-counter command decode
  logic [`PIT_NUM_CNT-1:0]  cnt_wr;
  logic [`PIT_NUM_CNT-1:0]  ctrl_cmd;
  logic [`PIT_NUM_CNT-1:0]  latch_cmd;
  logic [`PIT_NUM_CNT-1:0]  rd_sel;

  logic [15:0]              rd_src;
  logic                     rd_hi;
  logic                     rd_last;
  logic [7:0]               rd_byte;
  logic [`PIT_DATA_W-1:0]   rdata_q;

  function automatic pit_count_pkg::cnt_mode_e decode_mode(input logic [2:0] code);
    case (code)
      3'd2:    return pit_count_pkg::MODE_RATE;
      3'd3:    return pit_count_pkg::MODE_SQUARE;
      3'd4:    return pit_count_pkg::MODE_STROBE;
      default: return pit_count_pkg::MODE_TERMINAL;
    endcase
  endfunction

  // Address and data accepted together
  // One outstanding response per channel
  assign wr_hs   = axil_req.awvalid & axil_req.wvalid & (wr_st == CH_IDLE);
  assign rd_hs   = axil_req.arvalid & (rd_st == CH_IDLE);
  assign wr_idx  = axil_req.awaddr[`PIT_ADDR_W-1:2];
  assign rd_idx  = axil_req.araddr[`PIT_ADDR_W-1:2];
  assign wr_byte = axil_req.wdata[7:0];
  assign wr_acc  = pit_reg_pkg::access_e'(axil_req.wdata[5:4]);

  // Select value 3 (read-back) matches no counter
  always_comb begin
    for (int i = 0; i < `PIT_NUM_CNT; i++) begin
      cnt_wr[i]    = wr_hs && (wr_idx == 2'(i));
      ctrl_cmd[i]  = wr_hs && (wr_idx == CTRL_IDX) && (axil_req.wdata[7:6] == 2'(i));
      latch_cmd[i] = ctrl_cmd[i] && (wr_acc == pit_reg_pkg::ACC_LATCH);
      rd_sel[i]    = rd_hs && (rd_idx == 2'(i));
    end
  end

  // Byte picked for a read
  // Offset 0xC matches no counter and reads as zero
  always_comb begin
    rd_src  = 16'h0000;
    rd_hi   = 1'b0;
    rd_last = 1'b0;
    for (int i = 0; i < `PIT_NUM_CNT; i++) begin
      if (rd_idx == 2'(i)) begin
        rd_src = latch_vld[i] ? latch[i] : stat[i].count;
        case (acc[i])
          pit_reg_pkg::ACC_MSB: begin
            rd_hi   = 1'b1;
            rd_last = 1'b1;
          end
          pit_reg_pkg::ACC_LSB_MSB: begin
            rd_hi   = rd_msb[i];
            rd_last = rd_msb[i];
          end
          default: begin
            rd_hi   = 1'b0;
            rd_last = 1'b1;
          end
        endcase
      end
    end
    rd_byte = rd_hi ? rd_src[15:8] : rd_src[7:0];
  end

  // Response channel FSMs
  always_ff @(posedge WR_ or posedge LOAD) begin
    if (LOAD) begin
      wr_st <= CH_IDLE;
      rd_st <= CH_IDLE;
    end else begin
      case (wr_st)
        CH_IDLE: if (wr_hs) wr_st <= CH_RESP;
        default: if (axil_req.bready) wr_st <= CH_IDLE;
      endcase
      case (rd_st)
        CH_IDLE: if (rd_hs) rd_st <= CH_RESP;
        default: if (axil_req.rready) rd_st <= CH_IDLE;
      endcase
    end
  end

  // Access state, byte toggles, latch flag and strobes
  always_ff @(posedge WR_ or posedge LOAD) begin
    if (LOAD) begin
      for (int i = 0; i < `PIT_NUM_CNT; i++) begin
        acc[i]  <= pit_reg_pkg::ACC_LSB_MSB;
        mode[i] <= pit_count_pkg::MODE_TERMINAL;
      end
      wr_msb    <= '0;
      rd_msb    <= '0;
      latch_vld <= '0;
      arm_q     <= '0;
      stop_q    <= '0;
    end else begin
      arm_q  <= '0;
      stop_q <= '0;
      for (int i = 0; i < `PIT_NUM_CNT; i++) begin
        if (rd_sel[i]) begin
          if (acc[i] == pit_reg_pkg::ACC_LSB_MSB) rd_msb[i] <= ~rd_msb[i];
          // Latch released once its last byte is out
          if (rd_last) latch_vld[i] <= 1'b0;
        end
        if (latch_cmd[i] && !latch_vld[i]) begin
          latch_vld[i] <= 1'b1;
        end else if (ctrl_cmd[i] && !latch_cmd[i]) begin
          acc[i]       <= wr_acc;
          mode[i]      <= decode_mode(axil_req.wdata[3:1]);
          wr_msb[i]    <= 1'b0;
          rd_msb[i]    <= 1'b0;
          latch_vld[i] <= 1'b0;
          stop_q[i]    <= 1'b1;
        end
        if (cnt_wr[i]) begin
          case (acc[i])
            pit_reg_pkg::ACC_LSB_MSB: begin
              wr_msb[i] <= ~wr_msb[i];
              arm_q[i]  <= wr_msb[i];
            end
            pit_reg_pkg::ACC_LSB,
            pit_reg_pkg::ACC_MSB: arm_q[i] <= 1'b1;
            default: ;
          endcase
        end
      end
    end
  end

  // Initial counts, latched counts and read data
  always_ff @(posedge WR_ or posedge LOAD) begin
    if (LOAD) begin
      rdata_q <= '0;
      for (int i = 0; i < `PIT_NUM_CNT; i++) begin
        init[i]  <= 16'h0000;
        latch[i] <= 16'h0000;
      end
    end else begin
      if (rd_hs) rdata_q <= {{(`PIT_DATA_W-8){1'b0}}, rd_byte};
      for (int i = 0; i < `PIT_NUM_CNT; i++) begin
        if (cnt_wr[i]) begin
          case (acc[i])
            pit_reg_pkg::ACC_LSB: init[i] <= {8'h00, wr_byte};
            pit_reg_pkg::ACC_MSB: init[i] <= {wr_byte, 8'h00};
            pit_reg_pkg::ACC_LSB_MSB: begin
              if (wr_msb[i]) init[i][15:8] <= wr_byte;
              else init[i][7:0] <= wr_byte;
            end
            default: ;
          endcase
        end
        if (latch_cmd[i] && !latch_vld[i]) latch[i] <= stat[i].count;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `PIT_NUM_CNT; i++) begin
      cfg[i].mode = mode[i];
      cfg[i].init = init[i];
      cfg[i].arm  = arm_q[i];
      cfg[i].stop = stop_q[i];
    end
  end

  always_comb begin
    axil_rsp.awready = wr_hs;
    axil_rsp.wready  = wr_hs;
    axil_rsp.bvalid  = (wr_st == CH_RESP);
    axil_rsp.bresp   = pit_reg_pkg::RESP_OKAY;
    axil_rsp.arready = rd_hs;
    axil_rsp.rvalid  = (rd_st == CH_RESP);
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = pit_reg_pkg::RESP_OKAY;
  end

endmodule

// ==== hdl/pit_count_pkg.sv ====
// Counter-side types: operating mode enum, counter configuration and status structs
package pit_count_pkg;

  // Control word bits 3:1, modes 1 and 5 not supported
  typedef enum logic [2:0] {
    MODE_TERMINAL = 3'd0,
    MODE_RATE     = 3'd2,
    MODE_SQUARE   = 3'd3,
    MODE_STROBE   = 3'd4
  } cnt_mode_e;

  // Register block to one counter
  typedef struct packed {
    cnt_mode_e   mode;
    logic [15:0] init;
    // Complete count written
    logic        arm;
    // Control word written
    logic        stop;
  } cnt_cfg_t;

  // One counter back to the register block
  typedef struct packed {
    logic [15:0] count;
  } cnt_stat_t;

endpackage

// ==== hdl/pit_reg_pkg.sv ====
// Bus-side types: AXI4-Lite request and response bundles, response code, access-mode enum
`include "pit_consts.svh"

package pit_reg_pkg;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // Master to slave
  typedef struct packed {
    logic                   awvalid;
    logic [`PIT_ADDR_W-1:0] awaddr;
    logic                   wvalid;
    logic [`PIT_DATA_W-1:0] wdata;
    logic                   bready;
    logic                   arvalid;
    logic [`PIT_ADDR_W-1:0] araddr;
    logic                   rready;
  } axil_req_t;

  // Slave to master
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic [1:0]             bresp;
    logic                   arready;
    logic                   rvalid;
    logic [`PIT_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
  } axil_rsp_t;

  // Control word bits 5:4
  typedef enum logic [1:0] {
    ACC_LATCH   = 2'd0,
    ACC_LSB     = 2'd1,
    ACC_MSB     = 2'd2,
    ACC_LSB_MSB = 2'd3
  } access_e;

endpackage

// ==== hdl/pit_consts.svh ====
// Timer constants: counter count, AXI4-Lite address and data widths, synchronizer depth
`ifndef PIT_CONSTS_SVH
`define PIT_CONSTS_SVH

// Three independent counters, as on the 8253
`define PIT_NUM_CNT 3

// Four word registers at 0x0, 0x4, 0x8 and 0xC
`define PIT_ADDR_W 4

// Only the low byte carries data
`define PIT_DATA_W 32

// Flop depth for the counter clock and gate pins
`define PIT_SYNC_STAGES 2

`endif
